/* rtl/load_sel_pkg.sv */
package load_sel_pkg;

    // ports compared per selection
    localparam int num_ports = 4;

    // busy virtual-channel flags per port
    localparam int vc_width = 15;

    // holds 0 to 15 set flags
    localparam int count_width = 4;

    // binary port index
    localparam int port_idx_width = 2;

    typedef logic [vc_width-1:0]       busy_vec_t;
    typedef logic [count_width-1:0]    load_count_t;
    typedef logic [port_idx_width-1:0] port_idx_t;
    typedef logic [num_ports-1:0]      port_onehot_t;

    // one busy vector per port, port 0 in the low bits
    typedef struct packed {
        busy_vec_t [num_ports-1:0] busy;
    } load_req_t;

    // one set-bit count per port, same ordering as the request
    typedef struct packed {
        load_count_t [num_ports-1:0] count;
    } load_counts_t;

    // least-loaded port and its count
    typedef struct packed {
        port_idx_t   port_idx;
        load_count_t min_count;
    } sel_result_t;

endpackage

/* rtl/cs_gen.sv */
module cs_gen (
    input  logic [6:0] in,
    output logic [2:0] abc,
    output logic       s
);

    // split into a 4-bit and a 3-bit group
    logic [3:0] in1;
    logic [2:0] in2;
    // per-group set-bit counts
    logic [2:0] j1;
    logic [1:0] j2;
    // weight-two carries
    logic       a;
    logic       b;
    logic       c;

    assign {in2, in1} = in;

    assign j1 = 3'(in1[0]) + 3'(in1[1]) + 3'(in1[2]) + 3'(in1[3]);
    assign j2 = 2'(in2[0]) + 2'(in2[1]) + 2'(in2[2]);

    // parity of the whole 7-bit group
    assign s = j1[0] ^ j2[0];

    // at least two ones in the low group
    assign a = (j1 > 3'd1);

    // at least two ones in the high group
    assign b = (j2 > 2'd1);

    // third carry covers j1 of four, or both groups odd (their odd ones pair up)
    assign c = (j1 == 3'd4) | (j1[0] & j2[0]);

    assign abc = {a, b, c};

endmodule

/* rtl/parallel_counter.sv */
// (7,3) counter
module pc_7_3 (
    input  logic [6:0] in,
    output logic [2:0] out
);

    logic [2:0] abc;

    // parity straight into bit 0
    cs_gen cs (
        .in  (in),
        .abc (abc),
        .s   (out[0])
    );

    // carries all weigh two, so their sum is the upper part
    assign out[2:1] = 2'(abc[0]) + 2'(abc[1]) + 2'(abc[2]);

endmodule

// (15,4) counter
module pc_15_4 (
    input  logic [14:0] in,
    output logic [3:0]  out
);

    logic [2:0] abc0;
    logic [2:0] abc1;
    logic       s0;
    logic       s1;
    // carry out of the half-sum of the three weight-one bits
    logic       b2;

    // low seven flags
    cs_gen cs0 (
        .in  (in[6:0]),
        .abc (abc0),
        .s   (s0)
    );

    // next seven flags
    cs_gen cs1 (
        .in  (in[13:7]),
        .abc (abc1),
        .s   (s1)
    );

    // leftover bit plus both parities, at weight one
    assign {b2, out[0]} = 2'(in[14]) + 2'(s0) + 2'(s1);

    // seven weight-two bits counted by the small counter
    pc_7_3 pc_sub (
        .in  ({abc0, abc1, b2}),
        .out (out[3:1])
    );

endmodule

/* rtl/one_hot_mux.sv */
module one_hot_mux #(
    parameter type payload_t = logic [3:0]
) (
    input  load_sel_pkg::port_onehot_t                         sel,
    input  payload_t [load_sel_pkg::num_ports-1:0]             mux_in,
    output payload_t                                           mux_out
);

    import load_sel_pkg::*;

    // each input gated by its own select bit
    logic [$bits(payload_t)-1:0] masked [num_ports];
    // running OR of the gated inputs
    logic [$bits(payload_t)-1:0] or_acc;

    for (genvar i = 0; i < num_ports; i++) begin : g_mask
        assign masked[i] = mux_in[i] & {$bits(payload_t){sel[i]}};
    end

    always_comb begin
        or_acc = '0;
        for (int i = 0; i < num_ports; i++) begin
            or_acc = or_acc | masked[i];
        end
    end

    // only the selected input survives the mask when sel is one-hot
    assign mux_out = payload_t'(or_acc);

endmodule

/* rtl/load_count_stage.sv */
module load_count_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  load_sel_pkg::load_req_t    req,
    output logic                       counts_valid,
    output load_sel_pkg::load_counts_t counts
);

    import load_sel_pkg::*;

    // counter outputs before the pipeline register
    load_counts_t counts_next;

    // one (15,4) counter per port, all in parallel
    for (genvar p = 0; p < num_ports; p++) begin : g_port
        pc_15_4 pc (
            .in  (req.busy[p]),
            .out (counts_next.count[p])
        );
    end

    // strobe moves one stage down
    always_ff @(posedge clk) begin
        if (reset) begin
            counts_valid <= 1'b0;
        end else begin
            counts_valid <= in_valid;
        end
    end

    // capture only on a strobe, else hold
    always_ff @(posedge clk) begin
        if (in_valid) begin
            counts <= counts_next;
        end
    end

endmodule

/* rtl/min_select_stage.sv */
module min_select_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       counts_valid,
    input  load_sel_pkg::load_counts_t counts,
    output logic                       out_valid,
    output load_sel_pkg::sel_result_t  result
);

    import load_sel_pkg::*;

    // row i holds port i against every other port
    logic [num_ports-2:0] comp_array [num_ports];
    // one-hot least-loaded port
    port_onehot_t winner;
    // constant index per port for the encoder
    port_idx_t [num_ports-1:0] idx_table;
    port_idx_t   win_idx;
    load_count_t win_count;

    // triangular compare array
    // upper half compares directly, lower half reuses the inverse
    always_comb begin
        for (int i = 0; i < num_ports; i++) begin
            for (int j = 0; j < num_ports - 1; j++) begin
                if (i > j) begin
                    // port j already tested against port i in row j
                    comp_array[i][j] = ~comp_array[j][i-1];
                end else begin
                    // <= lets the lower index win a tie
                    comp_array[i][j] = (counts.count[i] <= counts.count[j+1]);
                end
            end
        end
    end

    // port wins when no other port beats it
    for (genvar i = 0; i < num_ports; i++) begin : g_win
        assign winner[i]    = &comp_array[i];
        assign idx_table[i] = port_idx_t'(i);
    end

    // one-hot to binary through the index table
    one_hot_mux #(
        .payload_t (port_idx_t)
    ) idx_mux (
        .sel     (winner),
        .mux_in  (idx_table),
        .mux_out (win_idx)
    );

    // winning count
    one_hot_mux #(
        .payload_t (load_count_t)
    ) count_mux (
        .sel     (winner),
        .mux_in  (counts.count),
        .mux_out (win_count)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= counts_valid;
        end
    end

    // result held between strobes
    always_ff @(posedge clk) begin
        if (counts_valid) begin
            result.port_idx  <= win_idx;
            result.min_count <= win_count;
        end
    end

endmodule

/* rtl/port_load_selector.sv */
module port_load_selector (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      in_valid,
    input  load_sel_pkg::load_req_t   req,
    output logic                      out_valid,
    output load_sel_pkg::sel_result_t result
);

    import load_sel_pkg::*;

    // between the count and select stages
    load_counts_t counts;
    logic         counts_valid;

    // stage 1 counts busy flags per port
    load_count_stage u_count (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .req          (req),
        .counts_valid (counts_valid),
        .counts       (counts)
    );

    // stage 2 picks the least-loaded port
    // result lands two cycles after the strobe
    min_select_stage u_select (
        .clk          (clk),
        .reset        (reset),
        .counts_valid (counts_valid),
        .counts       (counts),
        .out_valid    (out_valid),
        .result       (result)
    );

endmodule

/* tests/tb_port_load_selector.sv */
module tb_port_load_selector;

    import load_sel_pkg::*;

    logic         clk;
    logic         reset;
    logic         in_valid;
    load_req_t    req;
    logic         out_valid;
    sel_result_t  result;

    // expected results in issue order
    sel_result_t  expect_q [$];
    logic [31:0]  rng_state = 32'd102;
    string        cur_test = "reset";
    int           errors = 0;
    int           checks = 0;
    int           err_start = 0;
    int           tests_run = 0;
    int           strobes = 0;
    int           results_seen = 0;

    port_load_selector uut (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .req       (req),
        .out_valid (out_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // popcount per port and strict < so a tie keeps the lowest index
    function automatic sel_result_t ref_select(input load_req_t r);
        sel_result_t best;
        int cnt;
        int best_cnt;
        best_cnt = vc_width + 1;
        best = '0;
        for (int p = 0; p < num_ports; p++) begin
            cnt = 0;
            for (int b = 0; b < vc_width; b++) begin
                cnt += int'(r.busy[p][b]);
            end
            if (cnt < best_cnt) begin
                best_cnt = cnt;
                best.port_idx = port_idx_t'(p);
                best.min_count = load_count_t'(cnt);
            end
        end
        return best;
    endfunction

    // n ones per port in the low bits on even ports and the high bits on odd ports
    function automatic load_req_t known_req(input int c0, input int c1, input int c2,
                                            input int c3);
        load_req_t r;
        int c [num_ports];
        busy_vec_t v;
        c = '{c0, c1, c2, c3};
        for (int p = 0; p < num_ports; p++) begin
            v = busy_vec_t'((32'd1 << c[p]) - 32'd1);
            r.busy[p] = (p % 2 == 1) ? busy_vec_t'(v << (vc_width - c[p])) : v;
        end
        return r;
    endfunction

    task automatic rand_req(output load_req_t r);
        for (int p = 0; p < num_ports; p++) begin
            rng_state = lcg_next(rng_state);
            r.busy[p] = rng_state[30:16];
        end
    endtask

    task automatic check(input string name, input int expected, input int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("[FAIL] %s (%s): expected %0h, actual %0h", cur_test, name, expected,
                     actual);
        end
    endtask

    // one strobe with its expected result queued at the same edge
    task automatic send(input load_req_t r);
        @(posedge clk);
        in_valid <= 1'b1;
        req <= r;
        expect_q.push_back(ref_select(r));
        strobes++;
    endtask

    task automatic idle_cycle();
        @(posedge clk);
        in_valid <= 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        err_start = errors;
    endtask

    // stop strobing, wait for the pipe to empty, report the test
    task automatic end_test();
        int waited;
        waited = 0;
        idle_cycle();
        while (expect_q.size() != 0 && waited < 50) begin
            @(negedge clk);
            waited++;
        end
        if (expect_q.size() != 0) begin
            $display("timeout in %s: %0d results never came out", cur_test, expect_q.size());
            errors++;
            expect_q.delete();
        end
        tests_run++;
        if (errors == err_start) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, errors - err_start);
        end
    endtask

    // compare process reads outputs mid-cycle where they are stable
    always @(negedge clk) begin
        sel_result_t exp_res;
        if (!reset && out_valid) begin
            if (expect_q.size() == 0) begin
                errors++;
                $display("out_valid went high in %s with no request pending", cur_test);
            end else begin
                exp_res = expect_q.pop_front();
                results_seen++;
                check("result", int'(exp_res), int'(result));
            end
        end
    end

    initial begin
        load_req_t r;
        int n;
        int gap;
        int base;
        reset = 1'b1;
        in_valid = 1'b0;
        req = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;

        // quiet pipe, then one isolated strobe
        start_test("idle_and_latency");
        repeat (8) begin
            @(negedge clk);
            check("idle out_valid", 0, int'(out_valid));
        end
        send(known_req(3, 5, 7, 9));
        idle_cycle();
        n = 1;
        @(negedge clk);
        while (!out_valid && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!out_valid) begin
            errors++;
            $display("timeout in %s: out_valid never rose after the strobe", cur_test);
        end else begin
            check("strobe latency", 2, n);
        end
        @(negedge clk);
        check("out_valid width", 0, int'(out_valid));
        end_test();

        // corner vectors
        start_test("corner_values");
        send('0);
        send('1);
        end_test();

        // unique minimum walked across every port
        start_test("distinct_min");
        for (int p = 0; p < num_ports; p++) begin
            send(known_req(p == 0 ? 3 : 10, p == 1 ? 3 : 10, p == 2 ? 3 : 10, p == 3 ? 3 : 10));
            send(known_req(p == 0 ? 0 : 15, p == 1 ? 0 : 15, p == 2 ? 0 : 15, p == 3 ? 0 : 15));
        end
        end_test();

        // ties go to the lowest index
        start_test("tie_break");
        send(known_req(5, 5, 5, 5));
        send(known_req(7, 2, 7, 2));
        send(known_req(9, 9, 4, 4));
        send(known_req(6, 1, 1, 1));
        end_test();

        // back-to-back stream
        start_test("random_stream");
        for (int i = 0; i < 200; i++) begin
            rand_req(r);
            send(r);
        end
        end_test();

        // random gaps with one result per strobe
        start_test("random_gaps");
        base = results_seen;
        strobes = 0;
        for (int i = 0; i < 150; i++) begin
            rng_state = lcg_next(rng_state);
            gap = int'(rng_state[17:16]);
            for (int g = 0; g < gap; g++) begin
                idle_cycle();
            end
            rand_req(r);
            send(r);
        end
        end_test();
        check("result count", strobes, results_seen - base);

        $display("tests run: %0d, checks: %0d, errors: %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

/* vlog.f */
rtl/load_sel_pkg.sv
rtl/cs_gen.sv
rtl/parallel_counter.sv
rtl/one_hot_mux.sv
rtl/load_count_stage.sv
rtl/min_select_stage.sv
rtl/port_load_selector.sv
tests/tb_port_load_selector.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_port_load_selector -o tb_sim \
    && ./obj_dir/tb_sim > sim.log \
    || { cat sim.log 2>/dev/null; echo "build or simulation run failed"; exit 1; }

cat sim.log
! grep -q "=== FAIL ===" sim.log || { echo "simulation reported failure"; exit 1; }
